// File: design/emesh_pkg.sv
package emesh_pkg;

   // Memory geometry, 64-bit words
   localparam int MEM_AW    = 16;
   localparam int MEM_DEPTH = 1 << MEM_AW;

   // Byte address bit where the word address starts
   localparam int WORD_LSB  = 3;

   // Mesh address and data
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;

   // Memory side
   typedef logic [63:0]       mem_word_t;
   typedef logic [7:0]        byte_en_t;
   typedef logic [MEM_AW-1:0] mem_addr_t;

   // Transfer size: 1, 2, 4 or 8 bytes
   typedef enum logic [1:0]
   {
      DM_BYTE   = 2'b00,
      DM_SHORT  = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } datamode_t;

   // Mesh packet, 104 bits, write in the top bit
   typedef struct packed
   {
      logic      write;
      datamode_t datamode;
      logic [4:0] ctrlmode;
      addr_t     dstaddr;
      data_t     data;
      // Return address on a read, upper data half on a double write
      addr_t     srcaddr;
   } emesh_packet_t;

endpackage

// File: design/emem_access.sv
`timescale 1ns/1ps

module emem_access
(
   input  logic                     access_in,
   input  emesh_pkg::emesh_packet_t packet_in,
   input  logic                     wait_in,
   output logic                     wait_out,
   output logic                     rd_accept,
   output logic                     mem_en,
   output emesh_pkg::byte_en_t      mem_wen,
   output emesh_pkg::mem_addr_t     mem_addr,
   output emesh_pkg::mem_word_t     mem_din
);

   logic          accept;
   logic [2:0]    offset;
   emesh_pkg::data_t rep_data;

   // Request taken only when the mesh is not pushing back
   assign accept    = access_in & ~wait_in;
   assign wait_out  = access_in & wait_in;
   assign rd_accept = accept & ~packet_in.write;
   assign mem_en    = accept;

   // 64-bit memory, so drop the byte offset
   assign mem_addr = packet_in.dstaddr[emesh_pkg::WORD_LSB +: emesh_pkg::MEM_AW];
   assign offset   = packet_in.dstaddr[2:0];

   // Replicate small writes across the low 32 bits
   always_comb
   begin
      case (packet_in.datamode)
         emesh_pkg::DM_BYTE:
            rep_data = {4{packet_in.data[7:0]}};
         emesh_pkg::DM_SHORT:
            rep_data = {2{packet_in.data[15:0]}};
         default:
            rep_data = packet_in.data;
      endcase
   end

   // Double takes its upper half from srcaddr
   assign mem_din = (packet_in.datamode == emesh_pkg::DM_DOUBLE) ?
                    {packet_in.srcaddr, packet_in.data} :
                    {rep_data, rep_data};

   // Byte lanes for the access size at the given offset
   always_comb
   begin
      mem_wen = '0;
      if (packet_in.write)
      begin
         case (packet_in.datamode)
            emesh_pkg::DM_BYTE:
               mem_wen = 8'b0000_0001 << offset;
            emesh_pkg::DM_SHORT:
               mem_wen = 8'b0000_0011 << {offset[2:1], 1'b0};
            emesh_pkg::DM_WORD:
               mem_wen = 8'b0000_1111 << {offset[2], 2'b00};
            default:
               mem_wen = 8'b1111_1111;
         endcase
      end
   end

endmodule

// File: design/memory_sp.sv
`timescale 1ns/1ps

module memory_sp
(
   input  logic                 clk,
   input  logic                 en,
   input  emesh_pkg::byte_en_t  wen,
   input  emesh_pkg::mem_addr_t addr,
   input  emesh_pkg::mem_word_t din,
   output emesh_pkg::mem_word_t dout
);

   emesh_pkg::mem_word_t mem [0:emesh_pkg::MEM_DEPTH-1];

   // Byte-masked write, read of the old word on the same edge
   always_ff @(posedge clk)
   begin
      if (en)
      begin
         for (int i = 0; i < 8; i++)
         begin
            if (wen[i])
            begin
               mem[addr][i*8 +: 8] <= din[i*8 +: 8];
            end
         end
         dout <= mem[addr];
      end
   end

endmodule

// File: design/emesh_rdalign.sv
`timescale 1ns/1ps

module emesh_rdalign
(
   input  emesh_pkg::datamode_t datamode,
   input  logic [2:0]           offset,
   input  emesh_pkg::mem_word_t data_in,
   output emesh_pkg::mem_word_t data_out
);

   logic [5:0]           shift_bits;
   emesh_pkg::mem_word_t shifted;

   // Bit offset of the addressed lane, aligned to the access size
   always_comb
   begin
      case (datamode)
         emesh_pkg::DM_BYTE:
            shift_bits = {offset, 3'b000};
         emesh_pkg::DM_SHORT:
            shift_bits = {offset[2:1], 4'b0000};
         emesh_pkg::DM_WORD:
            shift_bits = {offset[2], 5'b00000};
         default:
            shift_bits = 6'd0;
      endcase
   end

   assign shifted = data_in >> shift_bits;

   // Zero-extend everything below a double
   always_comb
   begin
      case (datamode)
         emesh_pkg::DM_BYTE:
            data_out = {56'd0, shifted[7:0]};
         emesh_pkg::DM_SHORT:
            data_out = {48'd0, shifted[15:0]};
         emesh_pkg::DM_WORD:
            data_out = {32'd0, shifted[31:0]};
         default:
            data_out = data_in;
      endcase
   end

endmodule

// File: design/emem_response.sv
`timescale 1ns/1ps

module emem_response
(
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     rd_accept,
   input  emesh_pkg::emesh_packet_t req,
   input  emesh_pkg::mem_word_t     rd_data,
   output emesh_pkg::datamode_t     datamode_q,
   output logic [2:0]               offset_q,
   output logic                     access_out,
   output emesh_pkg::emesh_packet_t packet_out
);

   logic             access_q;
   logic [4:0]       ctrlmode_q;
   emesh_pkg::addr_t srcaddr_q;

   // Response strobe, one cycle after the read is taken
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         access_q <= 1'b0;
      end
      else
      begin
         access_q <= rd_accept;
      end
   end

   // Request fields held for the cycle the memory word comes back
   always_ff @(posedge clk)
   begin
      if (rd_accept)
      begin
         datamode_q <= req.datamode;
         ctrlmode_q <= req.ctrlmode;
         offset_q   <= req.dstaddr[2:0];
         srcaddr_q  <= req.srcaddr;
      end
   end

   assign access_out = access_q;

   // Reply goes back to the requester
   always_comb
   begin
      packet_out.write    = 1'b1;
      packet_out.datamode = datamode_q;
      packet_out.ctrlmode = ctrlmode_q;
      packet_out.dstaddr  = srcaddr_q;
      packet_out.data     = rd_data[31:0];
      packet_out.srcaddr  = rd_data[63:32];
   end

endmodule

// File: design/emesh_mem_node.sv
`timescale 1ns/1ps

module emesh_mem_node
(
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     access_in,
   input  emesh_pkg::emesh_packet_t packet_in,
   input  logic                     wait_in,
   output logic                     wait_out,
   output logic                     access_out,
   output emesh_pkg::emesh_packet_t packet_out
);

   logic                 rd_accept;
   logic                 mem_en;
   emesh_pkg::byte_en_t  mem_wen;
   emesh_pkg::mem_addr_t mem_addr;
   emesh_pkg::mem_word_t mem_din;
   emesh_pkg::mem_word_t mem_dout;
   emesh_pkg::mem_word_t rd_aligned;
   emesh_pkg::datamode_t datamode_q;
   logic [2:0]           offset_q;

   emem_access u_access
   (
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_in   (wait_in),
      .wait_out  (wait_out),
      .rd_accept (rd_accept),
      .mem_en    (mem_en),
      .mem_wen   (mem_wen),
      .mem_addr  (mem_addr),
      .mem_din   (mem_din)
   );

   memory_sp u_mem
   (
      .clk  (clk),
      .en   (mem_en),
      .wen  (mem_wen),
      .addr (mem_addr),
      .din  (mem_din),
      .dout (mem_dout)
   );

   // Alignment uses the fields registered alongside the memory read
   emesh_rdalign u_rdalign
   (
      .datamode (datamode_q),
      .offset   (offset_q),
      .data_in  (mem_dout),
      .data_out (rd_aligned)
   );

   emem_response u_response
   (
      .clk        (clk),
      .nreset     (nreset),
      .rd_accept  (rd_accept),
      .req        (packet_in),
      .rd_data    (rd_aligned),
      .datamode_q (datamode_q),
      .offset_q   (offset_q),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// File: tests/tb_emesh_mem_node.sv
`timescale 1ns/1ps

module tb_emesh_mem_node;

   localparam int PERIOD     = 100;
   localparam int RST_CYCLES = 8;
   localparam int N_WORDS    = 32;
   localparam int N_RANDOM   = 400;
   // Cycle slots of reset, directed phases and drain
   localparam int N_DIRECTED = 124;
   localparam logic [31:0] WIN_BASE = 32'h0000_2000;

   logic                     clk;
   logic                     nreset;
   logic                     access_in;
   emesh_pkg::emesh_packet_t packet_in;
   logic                     wait_in;
   logic                     wait_out;
   logic                     access_out;
   emesh_pkg::emesh_packet_t packet_out;

   // Byte model of a 256-byte window at WIN_BASE
   logic [7:0]               model_mem [0:255];
   logic                     rd_expected = 1'b0;
   emesh_pkg::emesh_packet_t exp_pkt = '0;
   int                       errors = 0;
   int                       rsp_count = 0;

   emesh_mem_node dut
   (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   function automatic emesh_pkg::emesh_packet_t make_req(input logic wr,
      input emesh_pkg::datamode_t dm, input int word, input int off,
      input logic [31:0] d, input logic [31:0] src, input logic [4:0] ctrl);
      emesh_pkg::emesh_packet_t p;
      logic [7:0]               idx;
      idx        = 8'(word * 8 + off);
      p.write    = wr;
      p.datamode = dm;
      p.ctrlmode = ctrl;
      p.dstaddr  = WIN_BASE | {24'd0, idx};
      p.data     = d;
      p.srcaddr  = src;
      return p;
   endfunction

   // Low bytes of data and then srcaddr bytes for a double
   function automatic void model_write(input emesh_pkg::emesh_packet_t p);
      int          base;
      int          n;
      logic [63:0] val;
      base = int'(p.dstaddr[7:0]);
      n    = 1 << int'(p.datamode);
      val  = {p.srcaddr, p.data};
      for (int i = 0; i < n; i++)
         model_mem[base + i] = val[i*8 +: 8];
   endfunction

   function automatic emesh_pkg::emesh_packet_t expect_read(input emesh_pkg::emesh_packet_t p);
      emesh_pkg::emesh_packet_t r;
      int                       base;
      int                       n;
      logic [63:0]              val;
      base = int'(p.dstaddr[7:0]);
      n    = 1 << int'(p.datamode);
      val  = '0;
      for (int i = 0; i < n; i++)
         val[i*8 +: 8] = model_mem[base + i];
      r.write    = 1'b1;
      r.datamode = p.datamode;
      r.ctrlmode = p.ctrlmode;
      r.dstaddr  = p.srcaddr;
      r.data     = val[31:0];
      r.srcaddr  = val[63:32];
      return r;
   endfunction

   // Model follows every accepted request
   always @(posedge clk)
   begin
      if (access_out)
         rsp_count++;
      if (nreset && access_in && !wait_in)
      begin
         if (packet_in.write)
            model_write(packet_in);
         else
            exp_pkt <= expect_read(packet_in);
      end
      rd_expected <= nreset && access_in && !wait_in && !packet_in.write;
   end

   wait_chk: assert property (@(posedge clk) wait_out == (access_in && wait_in))
      else
      begin
         errors++;
         $display("CHECK FAILED wait_out got %h expected %h",
                  $sampled(wait_out), $sampled(access_in && wait_in));
      end

   // Response exactly one cycle after each accepted read and never in reset
   access_chk: assert property (@(posedge clk) access_out == rd_expected)
      else
      begin
         errors++;
         $display("CHECK FAILED access_out got %h expected %h",
                  $sampled(access_out), $sampled(rd_expected));
      end

   packet_chk: assert property (@(posedge clk) !access_out || packet_out == exp_pkt)
      else
      begin
         errors++;
         $display("CHECK FAILED packet_out got %h expected %h",
                  $sampled(packet_out), $sampled(exp_pkt));
      end

   task automatic issue(input emesh_pkg::emesh_packet_t pkt);
      @(negedge clk);
      access_in = 1'b1;
      wait_in   = 1'b0;
      packet_in = pkt;
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(negedge clk);
         access_in = 1'b0;
         wait_in   = 1'b0;
      end
   endtask

   initial
   begin
      #((N_DIRECTED + N_RANDOM + 50) * PERIOD);
      $display("Watchdog expired before the test sequence finished");
      $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      logic [31:0]          rnd;
      emesh_pkg::datamode_t dm;
      int                   off;
      nreset    = 1'b0;
      access_in = 1'b0;
      wait_in   = 1'b0;
      packet_in = '0;
      rnd       = $urandom(1482);

      // Read strobes held during reset must not raise a response
      @(negedge clk);
      access_in = 1'b1;
      packet_in = make_req(1'b0, emesh_pkg::DM_DOUBLE, 0, 0, 32'd0, $urandom, 5'd1);
      repeat (RST_CYCLES - 1) @(negedge clk);
      nreset    = 1'b1;
      access_in = 1'b0;
      idle(2);

      // Fill the window with doubles and read them all back
      for (int w = 0; w < N_WORDS; w++)
         issue(make_req(1'b1, emesh_pkg::DM_DOUBLE, w, 0, $urandom, $urandom, 5'd0));
      for (int w = 0; w < N_WORDS; w++)
      begin
         rnd = $urandom;
         issue(make_req(1'b0, emesh_pkg::DM_DOUBLE, w, 0, 32'd0, $urandom, rnd[4:0]));
      end

      // Sub-word writes at every legal offset plus two partial merges
      for (int s = 0; s < 3; s++)
         for (int o = 0; o < 8; o += (1 << s))
            issue(make_req(1'b1, emesh_pkg::datamode_t'(s), s, o, $urandom, 32'd0, 5'd0));
      issue(make_req(1'b1, emesh_pkg::DM_BYTE, 3, 5, $urandom, 32'd0, 5'd0));
      issue(make_req(1'b1, emesh_pkg::DM_WORD, 4, 4, $urandom, 32'd0, 5'd0));
      for (int w = 0; w < 5; w++)
         issue(make_req(1'b0, emesh_pkg::DM_DOUBLE, w, 0, 32'd0, $urandom, 5'd3));

      // Back-to-back sub-word reads
      for (int s = 0; s < 3; s++)
         for (int o = 0; o < 8; o += (1 << s))
            issue(make_req(1'b0, emesh_pkg::datamode_t'(s), 5, o, 32'd0, $urandom, 5'd7));

      // Stalled write is withdrawn and stalled read waits for the release
      @(negedge clk);
      access_in = 1'b1;
      wait_in   = 1'b1;
      packet_in = make_req(1'b1, emesh_pkg::DM_DOUBLE, 6, 0, 32'hdead_beef, 32'hcafe_f00d, 5'd0);
      repeat (2) @(negedge clk);
      @(negedge clk);
      access_in = 1'b0;
      wait_in   = 1'b0;
      @(negedge clk);
      access_in = 1'b1;
      wait_in   = 1'b1;
      packet_in = make_req(1'b0, emesh_pkg::DM_DOUBLE, 6, 0, 32'd0, 32'h0bad_c0de, 5'd9);
      repeat (2) @(negedge clk);
      @(negedge clk);
      wait_in = 1'b0;
      @(negedge clk);
      access_in = 1'b0;

      // Random traffic with each stalled request held until taken
      for (int c = 0; c < N_RANDOM; c++)
      begin
         @(negedge clk);
         if (!(access_in && wait_in))
         begin
            rnd = $urandom;
            if (rnd[3:0] < 4'd11)
            begin
               dm        = emesh_pkg::datamode_t'(rnd[5:4]);
               off       = int'(rnd[13:11]) & ~((1 << int'(dm)) - 1);
               packet_in = make_req(rnd[14], dm, int'(rnd[10:6]), off,
                                    $urandom, $urandom, rnd[19:15]);
               access_in = 1'b1;
            end
            else
               access_in = 1'b0;
         end
         rnd     = $urandom;
         wait_in = (rnd[1:0] == 2'b00);
      end
      @(negedge clk);
      wait_in = 1'b0;
      idle(5);

      $display("Responses checked: %0d, errors: %0d", rsp_count, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: sim.f
design/emesh_pkg.sv
design/emem_access.sv
design/memory_sp.sv
design/emesh_rdalign.sv
design/emem_response.sv
design/emesh_mem_node.sv
tests/tb_emesh_mem_node.sv

// File: Makefile
TOP = tb_emesh_mem_node

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -qx "CHECKS FAILED" sim.log; then \
		echo "Simulation reported failures"; \
		exit 1; \
	fi
	@if ! grep -qx "ALL CHECKS PASSED" sim.log; then \
		echo "Simulation did not complete"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
